// ==== src/cgra_data_pkg.sv ====
//============================
// datapath types shared by the elements and the mesh links
// one link is the forward half only, ready travels beside it
//============================

package cgra_data_pkg;

    // datapath word
    localparam int data_width = 32;

    // edge lanes on the north input and south output side
    localparam int num_lanes = 4;

    typedef logic [data_width-1:0] data_t;

    // port order of every element, also the index of its link arrays
    typedef enum logic [1:0] {
        dir_north = 2'd0,
        dir_east  = 2'd1,
        dir_south = 2'd2,
        dir_west  = 2'd3
    } dir_t;

    // forward part of a valid/ready link
    typedef struct packed {
        logic  valid;
        data_t data;
    } link_t;

endpackage

// ==== src/cgra_cfg_pkg.sv ====
//============================
// configuration types of the 4x4 array
// element address is row * mesh_cols + col, row 0 on the north side
// immediate is zero-extended to the data width
//============================

package cgra_cfg_pkg;

    localparam int num_pe    = 16;
    localparam int mesh_cols = 4;

    typedef logic [3:0]        pe_addr_t;
    typedef logic [7:0]        imm_t;
    typedef logic [num_pe-1:0] pe_mask_t;

    // alu operation of one element
    typedef enum logic [1:0] {
        op_pass = 2'd0,
        op_add  = 2'd1,
        op_sub  = 2'd2,
        op_xor  = 2'd3
    } op_t;

    // per-element configuration, 14 bits
    typedef struct packed {
        cgra_data_pkg::dir_t src;
        cgra_data_pkg::dir_t dst;
        op_t                 op;
        imm_t                imm;
    } pe_cfg_t;

    // addressed configuration word, 19 bits
    typedef struct packed {
        logic     catch;
        pe_addr_t addr;
        pe_cfg_t  pe_cfg;
    } cfg_word_t;

endpackage

// ==== src/cgra_config_ctrl.sv ====
//============================
// configuration word decode and per-element run enables
// a configured flag stays set until reset
//============================

`timescale 1ns/1ps

module cgra_config_ctrl (
    input  logic                    clk,
    input  logic                    rst,

    input  cgra_cfg_pkg::cfg_word_t cfg_word,
    input  logic                    execute,

    output cgra_cfg_pkg::pe_mask_t  catch_mask,
    output cgra_cfg_pkg::pe_mask_t  run_mask
);

    cgra_cfg_pkg::pe_mask_t configured;

    // one-hot strobe for the addressed element
    always_comb begin
        catch_mask = '0;
        if (cfg_word.catch) begin
            catch_mask[cfg_word.addr] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            configured <= '0;
        end else begin
            configured <= configured | catch_mask;
        end
    end

    // replaces the old per-element clock gates
    assign run_mask = configured & {cgra_cfg_pkg::num_pe{execute}};

endmodule

// ==== src/pe_out_buffer.sv ====
//============================
// one-entry elastic output register
// full and draining accepts a new word in the same cycle
//============================

`timescale 1ns/1ps

module pe_out_buffer (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          in_valid,
    input  cgra_data_pkg::data_t          in_data,
    input  cgra_data_pkg::dir_t           dst,
    output logic                          in_ready,

    output cgra_data_pkg::link_t [3:0]    out_link,
    input  logic                 [3:0]    out_ready
);

    logic                 full;
    logic                 load;
    logic                 drain;
    cgra_data_pkg::data_t data_q;

    // only the dst ready can drain the entry
    assign drain    = full & out_ready[dst];
    assign in_ready = ~full | out_ready[dst];
    assign load     = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (drain) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= in_data;
        end
    end

    always_comb begin
        out_link = '0;
        out_link[dst].valid = full;
        out_link[dst].data  = data_q;
    end

endmodule

// ==== src/pe_core.sv ====
//============================
// one processing element: config register, source select, alu
// accepts only on src and drives only dst, one cycle of latency
// reconfigure while idle, a held word follows the new dst
//============================

`timescale 1ns/1ps

module pe_core (
    input  logic                          clk,
    input  logic                          rst,

    // configuration
    input  logic                          catch,
    input  cgra_cfg_pkg::pe_cfg_t         cfg,
    input  logic                          run,

    // mesh inputs, indexed by direction
    input  cgra_data_pkg::link_t [3:0]    in_link,
    output logic                 [3:0]    in_ready,

    // mesh outputs, indexed by direction
    output cgra_data_pkg::link_t [3:0]    out_link,
    input  logic                 [3:0]    out_ready
);

    cgra_cfg_pkg::pe_cfg_t  cfg_q;
    cgra_data_pkg::link_t   sel_link;
    cgra_data_pkg::data_t   imm_ext;
    cgra_data_pkg::data_t   result;
    logic                   buf_ready;
    logic                   buf_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_q <= '0;
        end else if (catch) begin
            cfg_q <= cfg;
        end
    end

    assign sel_link = in_link[cfg_q.src];
    assign imm_ext  = cgra_data_pkg::data_t'(cfg_q.imm);

    // halted elements neither take nor offer data
    assign buf_valid = run & sel_link.valid;

    always_comb begin
        in_ready = '0;
        in_ready[cfg_q.src] = run & buf_ready;
    end

    always_comb begin
        case (cfg_q.op)
            cgra_cfg_pkg::op_add: result = sel_link.data + imm_ext;
            cgra_cfg_pkg::op_sub: result = sel_link.data - imm_ext;
            cgra_cfg_pkg::op_xor: result = sel_link.data ^ imm_ext;
            default:              result = sel_link.data;
        endcase
    end

    pe_out_buffer out_buf_i (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .in_valid  ( buf_valid ),
        .in_data   ( result    ),
        .dst       ( cfg_q.dst ),
        .in_ready  ( buf_ready ),
        .out_link  ( out_link  ),
        .out_ready ( out_ready )
    );

endmodule

// ==== src/cgra_top.sv ====
//============================
// 4x4 array with elastic mesh links
// top row takes data_in, bottom row south outputs give data_out
// edge columns wrap their outer outputs into the row below
//============================

`timescale 1ns/1ps

module cgra_top (
    input  logic                                                   clk,
    input  logic                                                   rst,

    // configuration
    input  cgra_cfg_pkg::cfg_word_t                                cfg_word,
    input  logic                                                   execute,

    // north edge input lanes
    input  cgra_data_pkg::link_t [cgra_data_pkg::num_lanes-1:0]    data_in,
    output logic                 [cgra_data_pkg::num_lanes-1:0]    data_in_ready,

    // south edge output lanes
    output cgra_data_pkg::link_t [cgra_data_pkg::num_lanes-1:0]    data_out,
    input  logic                 [cgra_data_pkg::num_lanes-1:0]    data_out_ready
);

    localparam int last_row = cgra_cfg_pkg::num_pe / cgra_cfg_pkg::mesh_cols - 1;
    localparam int last_col = cgra_cfg_pkg::mesh_cols - 1;

    cgra_cfg_pkg::pe_mask_t     catch_mask;
    cgra_cfg_pkg::pe_mask_t     run_mask;

    // per-element link arrays, second index is the direction
    cgra_data_pkg::link_t [3:0] pe_in      [cgra_cfg_pkg::num_pe];
    logic                 [3:0] pe_in_rdy  [cgra_cfg_pkg::num_pe];
    cgra_data_pkg::link_t [3:0] pe_out     [cgra_cfg_pkg::num_pe];
    logic                 [3:0] pe_out_rdy [cgra_cfg_pkg::num_pe];

    cgra_config_ctrl config_ctrl_i (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cfg_word   ( cfg_word   ),
        .execute    ( execute    ),
        .catch_mask ( catch_mask ),
        .run_mask   ( run_mask   )
    );

    for (genvar i = 0; i < cgra_cfg_pkg::num_pe; i++) begin : g_pe
        localparam int row = i / cgra_cfg_pkg::mesh_cols;
        localparam int col = i % cgra_cfg_pkg::mesh_cols;

        // north side
        if (row == 0) begin : g_north_edge
            assign pe_in[i][cgra_data_pkg::dir_north]      = data_in[col];
            assign data_in_ready[col]                      = pe_in_rdy[i][cgra_data_pkg::dir_north];
            assign pe_out_rdy[i][cgra_data_pkg::dir_north] = 1'b0;
        end else begin : g_north_mesh
            assign pe_in[i][cgra_data_pkg::dir_north] =
                pe_out[i-cgra_cfg_pkg::mesh_cols][cgra_data_pkg::dir_south];
            assign pe_out_rdy[i][cgra_data_pkg::dir_north] =
                pe_in_rdy[i-cgra_cfg_pkg::mesh_cols][cgra_data_pkg::dir_south];
        end

        // south side
        if (row == last_row) begin : g_south_edge
            assign pe_in[i][cgra_data_pkg::dir_south]      = '0;
            assign data_out[col]                           = pe_out[i][cgra_data_pkg::dir_south];
            assign pe_out_rdy[i][cgra_data_pkg::dir_south] = data_out_ready[col];
        end else begin : g_south_mesh
            assign pe_in[i][cgra_data_pkg::dir_south] =
                pe_out[i+cgra_cfg_pkg::mesh_cols][cgra_data_pkg::dir_north];
            assign pe_out_rdy[i][cgra_data_pkg::dir_south] =
                pe_in_rdy[i+cgra_cfg_pkg::mesh_cols][cgra_data_pkg::dir_north];
        end

        // east side, right column wraps one row down
        if (col < last_col) begin : g_east_mesh
            assign pe_in[i][cgra_data_pkg::dir_east]      = pe_out[i+1][cgra_data_pkg::dir_west];
            assign pe_out_rdy[i][cgra_data_pkg::dir_east] = pe_in_rdy[i+1][cgra_data_pkg::dir_west];
        end else begin : g_east_wrap
            if (row == 0) begin : g_in_tie
                assign pe_in[i][cgra_data_pkg::dir_east] = '0;
            end else begin : g_in_wrap
                assign pe_in[i][cgra_data_pkg::dir_east] =
                    pe_out[i-cgra_cfg_pkg::mesh_cols][cgra_data_pkg::dir_east];
            end
            if (row == last_row) begin : g_out_tie
                assign pe_out_rdy[i][cgra_data_pkg::dir_east] = 1'b0;
            end else begin : g_out_wrap
                assign pe_out_rdy[i][cgra_data_pkg::dir_east] =
                    pe_in_rdy[i+cgra_cfg_pkg::mesh_cols][cgra_data_pkg::dir_east];
            end
        end

        // west side, left column wraps one row down
        if (col > 0) begin : g_west_mesh
            assign pe_in[i][cgra_data_pkg::dir_west]      = pe_out[i-1][cgra_data_pkg::dir_east];
            assign pe_out_rdy[i][cgra_data_pkg::dir_west] = pe_in_rdy[i-1][cgra_data_pkg::dir_east];
        end else begin : g_west_wrap
            if (row == 0) begin : g_in_tie
                assign pe_in[i][cgra_data_pkg::dir_west] = '0;
            end else begin : g_in_wrap
                assign pe_in[i][cgra_data_pkg::dir_west] =
                    pe_out[i-cgra_cfg_pkg::mesh_cols][cgra_data_pkg::dir_west];
            end
            if (row == last_row) begin : g_out_tie
                assign pe_out_rdy[i][cgra_data_pkg::dir_west] = 1'b0;
            end else begin : g_out_wrap
                assign pe_out_rdy[i][cgra_data_pkg::dir_west] =
                    pe_in_rdy[i+cgra_cfg_pkg::mesh_cols][cgra_data_pkg::dir_west];
            end
        end

        pe_core pe_i (
            .clk       ( clk             ),
            .rst       ( rst             ),
            .catch     ( catch_mask[i]   ),
            .cfg       ( cfg_word.pe_cfg ),
            .run       ( run_mask[i]     ),
            .in_link   ( pe_in[i]        ),
            .in_ready  ( pe_in_rdy[i]    ),
            .out_link  ( pe_out[i]       ),
            .out_ready ( pe_out_rdy[i]   )
        );
    end

endmodule

// ==== sim/cgra_props.sv ====
//==============================
// handshake checks on the cgra_top ports
// output stability assumes no reconfiguration under a held word
//==============================

`timescale 1ns/1ps

module cgra_props (
    input logic                                                clk,
    input logic                                                rst,
    input logic                                                execute,
    input logic                 [cgra_data_pkg::num_lanes-1:0] data_in_ready,
    input cgra_data_pkg::link_t [cgra_data_pkg::num_lanes-1:0] data_out,
    input logic                 [cgra_data_pkg::num_lanes-1:0] data_out_ready
);

    for (genvar l = 0; l < cgra_data_pkg::num_lanes; l++) begin : g_lane
        // a stalled word holds until taken
        held_p: assert property (@(posedge clk) disable iff (rst)
            data_out[l].valid && !data_out_ready[l]
            |=> data_out[l].valid && $stable(data_out[l].data))
            else $error("lane %0d output changed while stalled", l);

        known_p: assert property (@(posedge clk) disable iff (rst)
            !$isunknown(data_out[l].valid))
            else $error("lane %0d output valid is unknown", l);
    end

    halt_p: assert property (@(posedge clk) disable iff (rst)
        !execute |-> data_in_ready == '0)
        else $error("data_in_ready high while execute is low");

endmodule

bind cgra_top cgra_props props_i (
    .clk            ( clk            ),
    .rst            ( rst            ),
    .execute        ( execute        ),
    .data_in_ready  ( data_in_ready  ),
    .data_out       ( data_out       ),
    .data_out_ready ( data_out_ready )
);

// ==== sim/cgra_tb.sv ====
//==============================
// testbench for cgra_top, records from sim/cgra_cases.txt
// run from the project root, all record numbers are hex
// expected words are checked per lane in arrival order
//==============================

`timescale 1ns/1ps

module cgra_tb;

    logic                                                clk;
    logic                                                rst;
    cgra_cfg_pkg::cfg_word_t                             cfg_word;
    logic                                                execute;
    cgra_data_pkg::link_t [cgra_data_pkg::num_lanes-1:0] data_in;
    logic                 [cgra_data_pkg::num_lanes-1:0] data_in_ready;
    cgra_data_pkg::link_t [cgra_data_pkg::num_lanes-1:0] data_out;
    logic                 [cgra_data_pkg::num_lanes-1:0] data_out_ready;

    cgra_data_pkg::data_t in_q  [cgra_data_pkg::num_lanes][$];
    cgra_data_pkg::data_t exp_q [cgra_data_pkg::num_lanes][$];
    logic [31:0]          lfsr_state;
    logic                 rand_ready;
    int                   cycle_count;
    int                   cycle_limit;

    cgra_top dut_i (
        .clk            ( clk            ),
        .rst            ( rst            ),
        .cfg_word       ( cfg_word       ),
        .execute        ( execute        ),
        .data_in        ( data_in        ),
        .data_in_ready  ( data_in_ready  ),
        .data_out       ( data_out       ),
        .data_out_ready ( data_out_ready )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            cycle_count = cycle_count + 1;
            if (cycle_count >= cycle_limit) begin
                report_failure($sformatf("timeout, run still busy after %0d cycles", cycle_count));
            end
        end
    end

    // sample at the falling edge, drive at the rising edge
    task automatic step_cycle(input logic [cgra_data_pkg::num_lanes-1:0] quiet, input string test);
        logic [cgra_data_pkg::num_lanes-1:0] in_fire;
        @(negedge clk);
        for (int l = 0; l < cgra_data_pkg::num_lanes; l++) begin
            in_fire[l] = data_in[l].valid & data_in_ready[l];
            if (quiet[l]) begin
                assert (!data_in_ready[l] && !data_out[l].valid) else
                    report_failure($sformatf("%s: lane %0d active while it should be idle", test, l));
            end
            if (data_out[l].valid && data_out_ready[l]) begin
                assert (exp_q[l].size() > 0) else
                    report_failure($sformatf("%s: unexpected word on lane %0d", test, l));
                assert (data_out[l].data == exp_q[l][0]) else
                    report_failure($sformatf("mismatch %s lane %0d expected %h actual %h",
                                             test, l, exp_q[l][0], data_out[l].data));
                void'(exp_q[l].pop_front());
            end
        end
        @(posedge clk);
        for (int l = 0; l < cgra_data_pkg::num_lanes; l++) begin
            if (in_fire[l]) begin
                void'(in_q[l].pop_front());
            end
            if (in_q[l].size() > 0) begin
                data_in[l].valid <= 1'b1;
                data_in[l].data  <= in_q[l][0];
            end else begin
                data_in[l].valid <= 1'b0;
            end
            if (rand_ready) begin
                lfsr_state = lfsr_step(lfsr_state);
                data_out_ready[l] <= lfsr_state[0];
            end else begin
                data_out_ready[l] <= 1'b1;
            end
        end
    endtask

    task automatic apply_config(input string test, input logic [31:0] addr, input logic [31:0] src,
                                input logic [31:0] dst, input logic [31:0] op,
                                input logic [31:0] imm);
        cgra_cfg_pkg::cfg_word_t word;
        word.catch      = 1'b1;
        word.addr       = addr[3:0];
        word.pe_cfg.src = cgra_data_pkg::dir_t'(src[1:0]);
        word.pe_cfg.dst = cgra_data_pkg::dir_t'(dst[1:0]);
        word.pe_cfg.op  = cgra_cfg_pkg::op_t'(op[1:0]);
        word.pe_cfg.imm = imm[7:0];
        step_cycle('0, test);
        cfg_word <= word;
        step_cycle('0, test);
        cfg_word <= '0;
    endtask

    function automatic bit words_pending();
        for (int l = 0; l < cgra_data_pkg::num_lanes; l++) begin
            if (in_q[l].size() != 0 || exp_q[l].size() != 0) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    initial begin
        int           fd;
        int           n;
        int           records;
        int           lane;
        string        line;
        string        kind_s;
        string        name_s;
        logic [63:0]  kind_raw;
        logic [191:0] name_raw;
        logic [31:0]  f0, f1, f2, f3, f4;
        logic [31:0]  vals [4];

        rst            = 1'b1;
        cfg_word       = '0;
        execute        = 1'b0;
        data_in        = '0;
        data_out_ready = '1;
        lfsr_state     = 32'h4abf;
        rand_ready     = 1'b0;
        cycle_count    = 0;
        records        = 0;

        fd = $fopen("sim/cgra_cases.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open sim/cgra_cases.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                records++;
            end
        end
        $fclose(fd);
        // 40 cycles of budget per record
        cycle_limit = 40 * records;

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("sim/cgra_cases.txt", "r");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            kind_raw = '0;
            name_raw = '0;
            n = $sscanf(line, "%s %s %h %h %h %h %h", kind_raw, name_raw, f0, f1, f2, f3, f4);
            kind_s = string'(kind_raw);
            name_s = string'(name_raw);
            lane   = int'(f0);
            vals   = '{f1, f2, f3, f4};
            case (kind_s)
                "cfg": apply_config(name_s, f0, f1, f2, f3, f4);
                "exe": begin
                    step_cycle('0, name_s);
                    execute <= f0[0];
                end
                "bp":  rand_ready = f0[0];
                "in", "exp": begin
                    for (int k = 0; k < n - 3; k++) begin
                        if (kind_s == "in") begin
                            in_q[lane].push_back(vals[k]);
                        end else begin
                            exp_q[lane].push_back(vals[k]);
                        end
                    end
                end
                "idle": repeat (f1) step_cycle(f0[cgra_data_pkg::num_lanes-1:0], name_s);
                "run": begin
                    while (words_pending()) begin
                        step_cycle('0, name_s);
                    end
                end
                default: report_failure($sformatf("unknown record kind in line: %s", line));
            endcase
        end
        $fclose(fd);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== sim/cgra_cases.txt ====
# kind test args, all numbers hex
# cfg: addr src dst op imm   exe: level   bp: random ready on/off   run: drain all
# in, exp: lane then up to 4 words   idle: quiet lane mask, cycles
exe reset_idle 1
idle reset_idle f 10
cfg col_chain 0 0 2 1 05
cfg col_chain 4 0 2 3 ff
cfg col_chain 8 0 2 2 03
cfg col_chain c 0 2 0 00
cfg col_chain 1 0 2 2 10
cfg col_chain 5 0 2 1 20
cfg col_chain 9 0 2 3 0f
cfg col_chain d 0 2 1 01
idle col_chain c 4
in col_chain 0 00000010 12345678
in col_chain 1 00000005 ffffff00
exp col_chain 0 000000e7 1234567f
exp col_chain 1 0000001b ffffff20
run col_chain
cfg turn_east 2 0 1 1 01
cfg turn_east 3 3 2 3 80
cfg turn_east 7 0 2 0 00
cfg turn_east b 0 2 2 02
cfg turn_east f 0 2 1 04
in turn_east 2 00000100 000000ff
exp turn_east 3 00000183 00000182
run turn_east
cfg east_wrap 3 0 1 3 0f
cfg east_wrap 7 1 2 1 10
in east_wrap 3 00000020 abcd0000
exp east_wrap 3 00000041 abcd0021
run east_wrap
bp backpressure 1
in backpressure 0 00000000 000000f0 80000000 fffffffe
in backpressure 1 00000100 00000042
exp backpressure 0 000000f7 00000007 800000f7 000000f9
exp backpressure 1 00000120 0000005e
run backpressure
bp backpressure 0
exe halt 0
in halt 0 00000007
idle halt 1 10
exe halt 1
exp halt 0 000000f0
run halt
cfg reconfig 8 0 2 1 10
in reconfig 0 00000010
exp reconfig 0 000000fa
run reconfig

// ==== vlog.f ====
src/cgra_data_pkg.sv
src/cgra_cfg_pkg.sv
src/cgra_config_ctrl.sv
src/pe_out_buffer.sv
src/pe_core.sv
src/cgra_top.sv
sim/cgra_props.sv
sim/cgra_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cgra testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module cgra_tb -f vlog.f -o cgra_sim; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/cgra_sim 2>&1)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
